/* tb.f */
+incdir+verilog
+incdir+test
verilog/wo_bus_pkg.sv
verilog/wo_track_pkg.sv
verilog/busy_filter_if.sv
verilog/tag_heap_if.sv
verilog/busy_filter.sv
verilog/tag_heap.sv
verilog/order_ctrl.sv
verilog/write_order_shim.sv
test/tb_write_order.sv

/* test/tb_checks.svh */
// Compare tasks and the reference ordering model for the shim testbench.
// Included inside the testbench module, after the scoreboard arrays and
// the per-behavior error counters that these tasks use.

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// ============================================================
// Compare tasks for each kind of result
// ============================================================

task automatic check_tag(input int beh, input string name,
                         input wo_bus_pkg::tag_t exp, input wo_bus_pkg::tag_t act);
    if (act !== exp)
    begin
        $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, act);
        errs[beh]++;
    end
endtask

task automatic check_addr(input int beh, input string name,
                          input wo_bus_pkg::addr_t exp, input wo_bus_pkg::addr_t act);
    if (act !== exp)
    begin
        $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, act);
        errs[beh]++;
    end
endtask

task automatic check_data(input int beh, input string name,
                          input wo_bus_pkg::data_t exp, input wo_bus_pkg::data_t act);
    if (act !== exp)
    begin
        $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, act);
        errs[beh]++;
    end
endtask

task automatic check_flag(input int beh, input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
        $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, act);
        errs[beh]++;
    end
endtask

task automatic check_count(input int beh, input string name, input int exp, input int act);
    if (act != exp)
    begin
        $display("ERROR %s: expected 0x%0h, got 0x%0h", name, exp, act);
        errs[beh]++;
    end
endtask

// Failures that are not a wrong value are reported in words
task automatic report_fault(input int beh, input string msg);
    $display("Behavior %0d failure at %0t ns: %s", beh, $time, msg);
    errs[beh]++;
endtask

// ============================================================
// Reference ordering model
// ============================================================

// A read conflicts with an outstanding write to the same exact address.
// A write conflicts with any outstanding read or write to that address
function automatic logic has_conflict(input logic wr, input wo_bus_pkg::addr_t addr);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < `WO_WR_ENTRIES; i++)
    begin
        if (wr_busy[i] && wr_addr[i] == addr)
        begin
            hit = 1'b1;
        end
    end
    for (int i = 0; i < `WO_RD_ENTRIES; i++)
    begin
        if (wr && rd_busy[i] && rd_addr[i] == addr)
        begin
            hit = 1'b1;
        end
    end
    return hit;
endfunction

`endif

/* test/tb_write_order.sv */
// Random testbench for the write-ordering shim.
// Stimulus and the memory model run on the falling edge from one LFSR.
// Outputs are sampled at the rising edge, before any register updates.
// The memory model answers out of order and never stalls responses.

`default_nettype none

`include "wo_defines.svh"

module tb_write_order;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_REQS = 400;
    localparam int CLK_PERIOD = 20;
    localparam longint WATCHDOG_NS = longint'(NUM_REQS) * 64 * CLK_PERIOD;

    logic                 clk = 1'b0;
    logic                 resetb;
    logic                 req_valid;
    logic                 req_ready;
    logic                 req_is_write;
    logic                 req_check_order;
    wo_bus_pkg::addr_t    req_addr;
    wo_bus_pkg::data_t    req_data;
    wo_bus_pkg::tag_t     req_tag;
    logic                 mem_almfull;
    logic                 mem_req_valid;
    logic                 mem_req_is_write;
    wo_bus_pkg::addr_t    mem_req_addr;
    wo_bus_pkg::data_t    mem_req_data;
    wo_bus_pkg::mem_idx_t mem_req_idx;
    logic                 mem_rsp_valid;
    logic                 mem_rsp_is_write;
    wo_bus_pkg::mem_idx_t mem_rsp_idx;
    logic                 rsp_valid;
    logic                 rsp_is_write;
    wo_bus_pkg::tag_t     rsp_tag;

    // Stimulus state
    logic [15:0] lfsr = 16'd65;
    logic [31:0] rnd;
    int          k;
    int          reset_cycles = 0;
    int          n_sent = 0;
    int          n_accepted = 0;
    int          n_issued = 0;
    int          n_done = 0;
    int          errs [1:5] = '{default: 0};
    int          total;
    logic        bypass_seen = 1'b0;

    // Accepted but not yet issued, in acceptance order
    wo_bus_pkg::addr_t acc_addr [$];
    wo_bus_pkg::data_t acc_data [$];
    wo_bus_pkg::tag_t  acc_tag [$];
    logic              acc_wr [$];
    logic              acc_chk [$];

    // Scoreboard of outstanding requests by heap index
    logic              rd_busy [`WO_RD_ENTRIES] = '{default: 1'b0};
    logic              wr_busy [`WO_WR_ENTRIES] = '{default: 1'b0};
    wo_bus_pkg::addr_t rd_addr [`WO_RD_ENTRIES];
    wo_bus_pkg::addr_t wr_addr [`WO_WR_ENTRIES];
    wo_bus_pkg::tag_t  rd_tag [`WO_RD_ENTRIES];
    wo_bus_pkg::tag_t  wr_tag [`WO_WR_ENTRIES];
    int                rd_out = 0;
    int                wr_out = 0;

    // Memory model queue of issued requests not yet answered
    logic                 pend_wr [$];
    wo_bus_pkg::mem_idx_t pend_idx [$];

    `include "tb_checks.svh"

    write_order_shim UUT (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    // 16-bit Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    // ============================================================
    // Falling edge reset, memory model and request source
    // ============================================================

    always @(negedge clk)
    begin
        if (!resetb)
        begin
            reset_cycles++;
            resetb = (reset_cycles == 3);
        end
        else
        begin
            // Almost-full is raised about one cycle in eight
            take_bits(3, rnd);
            mem_almfull = (rnd[2:0] == 3'd0);
            mem_rsp_valid = 1'b0;
            take_bits(1, rnd);
            if (pend_idx.size() > 0 && rnd[0])
            begin
                // Any pending request may be answered, so responses come out of order
                take_bits(4, rnd);
                k = int'(rnd[3:0]) % pend_idx.size();
                mem_rsp_valid = 1'b1;
                mem_rsp_is_write = pend_wr[k];
                mem_rsp_idx = pend_idx[k];
                pend_wr.delete(k);
                pend_idx.delete(k);
            end
            // Fields change only once the previous request was accepted
            if (n_accepted == n_sent)
            begin
                req_valid = 1'b0;
                take_bits(2, rnd);
                if (n_sent < NUM_REQS && rnd[1:0] != 2'd0)
                begin
                    req_valid = 1'b1;
                    take_bits(1, rnd);
                    req_is_write = rnd[0];
                    take_bits(2, rnd);
                    req_check_order = (rnd[1:0] != 2'd0);
                    // Eight addresses only, so same-address traffic is common
                    take_bits(3, rnd);
                    req_addr = 32'h4000_0000 | (32'(rnd[2:0]) << 8);
                    take_bits(32, rnd);
                    req_data = rnd;
                    take_bits(8, rnd);
                    req_tag = rnd[7:0];
                    n_sent++;
                end
            end
        end
    end

    // ============================================================
    // Rising edge scoreboard
    // ============================================================

    task automatic note_issue();
        wo_bus_pkg::addr_t addr;
        wo_bus_pkg::tag_t  tag;
        logic              wr;
        logic              chk;
        int                idx;
        if (mem_almfull)
        begin
            report_fault(4, "request issued while mem_almfull was high");
        end
        if (acc_addr.size() == 0)
        begin
            report_fault(3, "request issued with no accepted request waiting");
            return;
        end
        addr = acc_addr.pop_front();
        tag = acc_tag.pop_front();
        wr = acc_wr.pop_front();
        chk = acc_chk.pop_front();
        idx = int'(mem_req_idx);
        check_addr(3, "mem_req_addr", addr, mem_req_addr);
        check_data(3, "mem_req_data", acc_data.pop_front(), mem_req_data);
        check_flag(3, "mem_req_is_write", wr, mem_req_is_write);
        if (has_conflict(wr, addr))
        begin
            if (chk)
            begin
                report_fault(2, "ordered request issued over a same-address conflict");
            end
            else
            begin
                bypass_seen = 1'b1;
            end
        end
        // Every issue counts, whether or not its index was accepted below
        if (wr)
        begin
            wr_out++;
        end
        else
        begin
            rd_out++;
        end
        if (wr && (idx >= `WO_WR_ENTRIES || wr_busy[idx]))
        begin
            report_fault(4, "write index out of range or still outstanding");
        end
        else if (!wr && rd_busy[idx])
        begin
            report_fault(4, "read index still outstanding");
        end
        else if (wr)
        begin
            wr_busy[idx] = 1'b1;
            wr_addr[idx] = addr;
            wr_tag[idx] = tag;
        end
        else
        begin
            rd_busy[idx] = 1'b1;
            rd_addr[idx] = addr;
            rd_tag[idx] = tag;
        end
        if (rd_out > `WO_RD_ENTRIES || wr_out > `WO_WR_ENTRIES)
        begin
            report_fault(4, "outstanding count above the heap depth");
        end
        pend_wr.push_back(wr);
        pend_idx.push_back(mem_req_idx);
        n_issued++;
    endtask

    task automatic note_response();
        int idx;
        idx = int'(mem_rsp_idx);
        check_flag(1, "rsp_is_write", mem_rsp_is_write, rsp_is_write);
        if (mem_rsp_is_write)
        begin
            wr_out--;
        end
        else
        begin
            rd_out--;
        end
        if (mem_rsp_is_write ? !wr_busy[idx] : !rd_busy[idx])
        begin
            report_fault(1, "response for an index that is not outstanding");
        end
        else if (mem_rsp_is_write)
        begin
            check_tag(1, "rsp_tag", wr_tag[idx], rsp_tag);
            wr_busy[idx] = 1'b0;
        end
        else
        begin
            check_tag(1, "rsp_tag", rd_tag[idx], rsp_tag);
            rd_busy[idx] = 1'b0;
        end
        n_done++;
    endtask

    // Issue is scored before the response, since the filter still sees
    // an entry during the cycle of its response
    always @(posedge clk)
    begin
        if (resetb)
        begin
            if (req_valid && req_ready)
            begin
                acc_addr.push_back(req_addr);
                acc_data.push_back(req_data);
                acc_tag.push_back(req_tag);
                acc_wr.push_back(req_is_write);
                acc_chk.push_back(req_check_order);
                n_accepted++;
            end
            if (mem_req_valid)
            begin
                note_issue();
            end
            // The response strobe follows the memory strobe in the same cycle
            check_flag(1, "rsp_valid", mem_rsp_valid, rsp_valid);
            if (mem_rsp_valid)
            begin
                note_response();
            end
        end
    end

    task automatic show_result(input int beh, input string what);
        $display("Behavior %0d, %s: %s, %0d errors", beh, what,
                 (errs[beh] == 0) ? "ok" : "failed", errs[beh]);
    endtask

    // ============================================================
    // Run control
    // ============================================================

    initial
    begin
        resetb = 1'b0;
        req_valid = 1'b0;
        req_is_write = 1'b0;
        req_check_order = 1'b0;
        req_addr = '0;
        req_data = '0;
        req_tag = '0;
        mem_almfull = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp_is_write = 1'b0;
        mem_rsp_idx = '0;
        wait (n_done == NUM_REQS);
        repeat (4) @(posedge clk);
        check_count(5, "requests accepted", NUM_REQS, n_accepted);
        check_count(5, "requests issued", NUM_REQS, n_issued);
        check_count(4, "reads outstanding", 0, rd_out);
        check_count(4, "writes outstanding", 0, wr_out);
        if (!bypass_seen)
        begin
            report_fault(5, "no unordered request passed a same-address conflict");
        end
        show_result(1, "tag restore");
        show_result(2, "ordered requests wait for conflicts");
        show_result(3, "issue order and payload");
        show_result(4, "almost-full and heap limits");
        show_result(5, "unordered bypass and completion");
        total = 0;
        for (int b = 1; b <= 5; b++)
        begin
            total += errs[b];
        end
        $display("%0d requests completed, %0d errors in total", n_done, total);
        if (total == 0)
        begin
            $display("TEST PASSED");
        end
        else
        begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // Each request gets 64 cycles on average before the run is abandoned
    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired with %0d of %0d requests complete", n_done, NUM_REQS);
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog/busy_filter.sv */
// Small CAM of address hashes for requests still outstanding at memory.
// Slots are addressed by heap index, so the heap decides which slot is free.
// Inserts and removes take effect at the next clock edge. A lookup in the
// same cycle still sees an entry that is being removed.

`default_nettype none

module busy_filter #(
    parameter int N_ENTRIES = 4
) (
    input  wire logic    clk,
    input  wire logic    resetb,
    busy_filter_if.filter f
);

    // One valid bit and one stored hash per slot
    logic [N_ENTRIES-1:0] valid;
    wo_track_pkg::hash_t  hashes [N_ENTRIES];

    // Per-slot match against the hash under test
    logic [N_ENTRIES-1:0] match;

    always_comb
    begin
        for (int i = 0; i < N_ENTRIES; i++)
        begin
            match[i] = valid[i] && (hashes[i] == f.test_hash);
        end
    end

    assign f.conflict = f.test_en && (|match);

    // A slot turns valid at insert and empty again at remove
    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            valid <= '0;
        end
        else
        begin
            if (f.insert_en)
            begin
                valid[f.insert_idx] <= 1'b1;
            end
            if (f.remove_en)
            begin
                valid[f.remove_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (f.insert_en)
        begin
            hashes[f.insert_idx] <= f.insert_hash;
        end
    end

    // The heap must hand out only slots that the filter also sees as free
    a_insert_free: assert property (@(posedge clk) disable iff (!resetb)
        f.insert_en |-> !valid[f.insert_idx]);

    // Memory must return only indices that were issued and not yet answered
    a_remove_busy: assert property (@(posedge clk) disable iff (!resetb)
        f.remove_en |-> valid[f.remove_idx]);

endmodule

`default_nettype wire

/* verilog/busy_filter_if.sv */
// Link between the control FSM and one busy-address filter.
// The conflict result is combinational from test_en and test_hash.

`default_nettype none

interface busy_filter_if #(parameter int N_ENTRIES = 4);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    // Lookup of the held request's hash
    logic                  test_en;
    wo_track_pkg::hash_t   test_hash;
    logic                  conflict;

    // Insert at issue, using the heap index as the slot
    logic                  insert_en;
    logic [IDX_BITS-1:0]   insert_idx;
    wo_track_pkg::hash_t   insert_hash;

    // Remove when the response returns
    logic                  remove_en;
    logic [IDX_BITS-1:0]   remove_idx;

    modport ctrl (
        output test_en, test_hash, insert_en, insert_idx, insert_hash,
        output remove_en, remove_idx,
        input  conflict
    );

    modport filter (
        input  test_en, test_hash, insert_en, insert_idx, insert_hash,
        input  remove_en, remove_idx,
        output conflict
    );

endinterface

`default_nettype wire

/* verilog/order_ctrl.sv */
// Holds one accepted request, tests it against the busy filters and issues it.
// Only the held request can block, so issue order equals acceptance order.
// Reads test the write filter only; writes test both filters.
// Requests without check_order skip the filter test but are still tracked.
// Responses pass straight through with the saved tag restored.

`default_nettype none

module order_ctrl (
    input  wire logic                   clk,
    input  wire logic                   resetb,
    // Request side with a valid/ready handshake
    input  wire logic                   req_valid,
    output logic                        req_ready,
    input  wire logic                   req_is_write,
    input  wire logic                   req_check_order,
    input  wire wo_bus_pkg::addr_t      req_addr,
    input  wire wo_bus_pkg::data_t      req_data,
    input  wire wo_bus_pkg::tag_t       req_tag,
    // Memory side with strobes and almost-full
    input  wire logic                   mem_almfull,
    output logic                        mem_req_valid,
    output logic                        mem_req_is_write,
    output wo_bus_pkg::addr_t           mem_req_addr,
    output wo_bus_pkg::data_t           mem_req_data,
    output wo_bus_pkg::mem_idx_t        mem_req_idx,
    input  wire logic                   mem_rsp_valid,
    input  wire logic                   mem_rsp_is_write,
    input  wire wo_bus_pkg::mem_idx_t   mem_rsp_idx,
    // Response toward the caller
    output logic                        rsp_valid,
    output logic                        rsp_is_write,
    output wo_bus_pkg::tag_t            rsp_tag,
    busy_filter_if.ctrl                 rd_filt,
    busy_filter_if.ctrl                 wr_filt,
    tag_heap_if.ctrl                    rd_heap,
    tag_heap_if.ctrl                    wr_heap
);

    // ============================================================
    // Holding stage
    // ============================================================

    // Goes high one cycle after reset is released and stays high
    logic                  running;
    logic                  hold_valid;
    logic                  hold_is_write;
    logic                  hold_check;
    wo_bus_pkg::addr_t     hold_addr;
    wo_bus_pkg::data_t     hold_data;
    wo_bus_pkg::tag_t      hold_tag;
    wo_track_pkg::hash_t   hold_hash;

    logic                  heap_full;
    logic                  blocked;
    logic                  issue;
    wo_bus_pkg::rd_idx_t   rsp_rd_idx;
    wo_bus_pkg::wr_idx_t   rsp_wr_idx;

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            running    <= 1'b0;
            hold_valid <= 1'b0;
        end
        else
        begin
            running <= 1'b1;
            if (req_valid && req_ready)
            begin
                hold_valid <= 1'b1;
            end
            else if (issue)
            begin
                hold_valid <= 1'b0;
            end
        end
    end

    // Payload and hash are captured on acceptance
    always_ff @(posedge clk)
    begin
        if (req_valid && req_ready)
        begin
            hold_is_write <= req_is_write;
            hold_check    <= req_check_order;
            hold_addr     <= req_addr;
            hold_data     <= req_data;
            hold_tag      <= req_tag;
            hold_hash     <= wo_track_pkg::addr_hash(req_addr);
        end
    end

    // ============================================================
    // Blocking decision and issue
    // ============================================================

    // The read filter matters only to writes
    assign rd_filt.test_en   = hold_valid && hold_check && hold_is_write;
    assign rd_filt.test_hash = hold_hash;
    assign wr_filt.test_en   = hold_valid && hold_check;
    assign wr_filt.test_hash = hold_hash;

    assign heap_full = hold_is_write ? !wr_heap.not_full : !rd_heap.not_full;
    assign blocked   = mem_almfull || heap_full || rd_filt.conflict || wr_filt.conflict;
    assign issue     = hold_valid && !blocked;

    // Accept into an empty stage or one that drains this cycle
    assign req_ready = running && (!hold_valid || issue);

    assign mem_req_valid    = issue;
    assign mem_req_is_write = hold_is_write;
    assign mem_req_addr     = hold_addr;
    assign mem_req_data     = hold_data;
    // Heap index goes out in place of the caller's tag
    assign mem_req_idx = hold_is_write ? wo_bus_pkg::mem_idx_t'(wr_heap.alloc_idx)
                                       : wo_bus_pkg::mem_idx_t'(rd_heap.alloc_idx);

    // Allocation and filter insert share the heap index
    assign rd_heap.alloc_en    = issue && !hold_is_write;
    assign rd_heap.alloc_tag   = hold_tag;
    assign rd_filt.insert_en   = issue && !hold_is_write;
    assign rd_filt.insert_idx  = rd_heap.alloc_idx;
    assign rd_filt.insert_hash = hold_hash;

    assign wr_heap.alloc_en    = issue && hold_is_write;
    assign wr_heap.alloc_tag   = hold_tag;
    assign wr_filt.insert_en   = issue && hold_is_write;
    assign wr_filt.insert_idx  = wr_heap.alloc_idx;
    assign wr_filt.insert_hash = hold_hash;

    // ============================================================
    // Response restore
    // ============================================================

    assign rsp_rd_idx = wo_bus_pkg::rd_idx_t'(mem_rsp_idx);
    assign rsp_wr_idx = wo_bus_pkg::wr_idx_t'(mem_rsp_idx);

    // Heap and filter entries are released at the edge that ends this cycle
    assign rd_heap.free_en    = mem_rsp_valid && !mem_rsp_is_write;
    assign rd_heap.free_idx   = rsp_rd_idx;
    assign rd_filt.remove_en  = mem_rsp_valid && !mem_rsp_is_write;
    assign rd_filt.remove_idx = rsp_rd_idx;

    assign wr_heap.free_en    = mem_rsp_valid && mem_rsp_is_write;
    assign wr_heap.free_idx   = rsp_wr_idx;
    assign wr_filt.remove_en  = mem_rsp_valid && mem_rsp_is_write;
    assign wr_filt.remove_idx = rsp_wr_idx;

    assign rsp_valid    = mem_rsp_valid;
    assign rsp_is_write = mem_rsp_is_write;
    assign rsp_tag      = mem_rsp_is_write ? wr_heap.free_tag : rd_heap.free_tag;

    // Memory may drop requests that arrive while it signals almost full
    a_no_issue_almfull: assert property (@(posedge clk) disable iff (!resetb)
        mem_almfull |-> !mem_req_valid);

endmodule

`default_nettype wire

/* verilog/tag_heap.sv */
// Free-list allocator that saves the caller's tag per outstanding request.
// The lowest free index is always offered, so allocation is deterministic.
// An index freed in a cycle becomes available at the next edge.

`default_nettype none

module tag_heap #(
    parameter int N_ENTRIES = 4
) (
    input  wire logic  clk,
    input  wire logic  resetb,
    tag_heap_if.heap   h
);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    // Set while an index is held by an outstanding request
    logic [N_ENTRIES-1:0] busy;
    wo_bus_pkg::tag_t     tags [N_ENTRIES];

    // ============================================================
    // Allocation
    // ============================================================

    // Scan from the top so the lowest free index wins
    always_comb
    begin
        h.alloc_idx = '0;
        for (int i = N_ENTRIES - 1; i >= 0; i--)
        begin
            if (!busy[i])
            begin
                h.alloc_idx = IDX_BITS'(i);
            end
        end
    end

    assign h.not_full = !(&busy);

    // Saved tag is looked up directly by the returning index
    assign h.free_tag = tags[h.free_idx];

    always_ff @(posedge clk)
    begin
        if (!resetb)
        begin
            busy <= '0;
        end
        else
        begin
            if (h.alloc_en)
            begin
                busy[h.alloc_idx] <= 1'b1;
            end
            // A free never hits the index being allocated, since that one is idle
            if (h.free_en)
            begin
                busy[h.free_idx] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (h.alloc_en)
        begin
            tags[h.alloc_idx] <= h.alloc_tag;
        end
    end

    // The control FSM must block issue while this heap is full
    a_alloc_not_full: assert property (@(posedge clk) disable iff (!resetb)
        h.alloc_en |-> h.not_full);

endmodule

`default_nettype wire

/* verilog/tag_heap_if.sv */
// Link between the control FSM and one tag heap.
// free_tag is read combinationally at free_idx, in the cycle of the free.

`default_nettype none

interface tag_heap_if #(parameter int N_ENTRIES = 4);

    localparam int IDX_BITS = $clog2(N_ENTRIES);

    // Allocation at issue
    logic                  alloc_en;
    wo_bus_pkg::tag_t      alloc_tag;
    logic                  not_full;
    logic [IDX_BITS-1:0]   alloc_idx;

    // Release at response, with the saved tag read back
    logic                  free_en;
    logic [IDX_BITS-1:0]   free_idx;
    wo_bus_pkg::tag_t      free_tag;

    modport ctrl (
        output alloc_en, alloc_tag, free_en, free_idx,
        input  not_full, alloc_idx, free_tag
    );

    modport heap (
        input  alloc_en, alloc_tag, free_en, free_idx,
        output not_full, alloc_idx, free_tag
    );

endinterface

`default_nettype wire

/* verilog/wo_bus_pkg.sv */
// Types seen on the request port and on the memory port.
// The memory index field is as wide as the wider of the two heap indices.
// A write index is zero-extended into it.

`default_nettype none

`include "wo_defines.svh"

package wo_bus_pkg;

    typedef logic [`WO_ADDR_BITS-1:0] addr_t;
    typedef logic [`WO_DATA_BITS-1:0] data_t;
    typedef logic [`WO_TAG_BITS-1:0]  tag_t;

    // Index widths follow from the heap depths
    localparam int RD_IDX_BITS = $clog2(`WO_RD_ENTRIES);
    localparam int WR_IDX_BITS = $clog2(`WO_WR_ENTRIES);
    localparam int MEM_IDX_BITS = (RD_IDX_BITS > WR_IDX_BITS) ? RD_IDX_BITS : WR_IDX_BITS;

    typedef logic [RD_IDX_BITS-1:0]  rd_idx_t;
    typedef logic [WR_IDX_BITS-1:0]  wr_idx_t;
    typedef logic [MEM_IDX_BITS-1:0] mem_idx_t;

endpackage

`default_nettype wire

/* verilog/wo_defines.svh */
// Widths and depths shared by the write-ordering shim and its testbench.
// The entry counts set the heap index widths, so memory must return the
// index it was given, unchanged, on mem_rsp_idx.
// Each entry count must be at least 2.

`ifndef WO_DEFINES_SVH
`define WO_DEFINES_SVH

// Request payload widths
`define WO_ADDR_BITS 32
`define WO_DATA_BITS 32
`define WO_TAG_BITS 8

// Folded address hash. Fewer bits mean more false conflicts
`define WO_HASH_BITS 6

// Outstanding requests allowed per class
`define WO_RD_ENTRIES 8
`define WO_WR_ENTRIES 4

`endif

/* verilog/wo_track_pkg.sv */
// Address tracking types for the busy-address filters.
// The hash is lossy, so two different addresses may share a hash and
// block each other. That costs throughput but never breaks ordering.

`default_nettype none

`include "wo_defines.svh"

package wo_track_pkg;

    typedef logic [`WO_HASH_BITS-1:0] hash_t;

    // ============================================================
    // Address hash
    // ============================================================

    // XOR-fold the address in WO_HASH_BITS wide slices.
    // Bit i of the address lands on bit (i mod WO_HASH_BITS) of the hash,
    // so the last slice may be partial
    function automatic hash_t addr_hash(input wo_bus_pkg::addr_t addr);
        hash_t h;
        h = '0;
        for (int i = 0; i < `WO_ADDR_BITS; i++)
        begin
            h[i % `WO_HASH_BITS] = h[i % `WO_HASH_BITS] ^ addr[i];
        end
        return h;
    endfunction

endpackage

`default_nettype wire

/* verilog/write_order_shim.sv */
// Write-ordering shim between a request source and a memory.
// Memory may answer out of order but must echo mem_req_idx and the
// is_write flag. Responses cannot be stalled.
// Up to WO_RD_ENTRIES reads and WO_WR_ENTRIES writes may be outstanding.

`default_nettype none

`include "wo_defines.svh"

module write_order_shim (
    input  wire logic                   clk,
    input  wire logic                   resetb,
    input  wire logic                   req_valid,
    output logic                        req_ready,
    input  wire logic                   req_is_write,
    input  wire logic                   req_check_order,
    input  wire wo_bus_pkg::addr_t      req_addr,
    input  wire wo_bus_pkg::data_t      req_data,
    input  wire wo_bus_pkg::tag_t       req_tag,
    input  wire logic                   mem_almfull,
    output logic                        mem_req_valid,
    output logic                        mem_req_is_write,
    output wo_bus_pkg::addr_t           mem_req_addr,
    output wo_bus_pkg::data_t           mem_req_data,
    output wo_bus_pkg::mem_idx_t        mem_req_idx,
    input  wire logic                   mem_rsp_valid,
    input  wire logic                   mem_rsp_is_write,
    input  wire wo_bus_pkg::mem_idx_t   mem_rsp_idx,
    output logic                        rsp_valid,
    output logic                        rsp_is_write,
    output wo_bus_pkg::tag_t            rsp_tag
);

    // Filter slots and heap entries are paired, so each pair shares a depth
    busy_filter_if #(.N_ENTRIES(`WO_RD_ENTRIES)) rd_filt_if ();
    busy_filter_if #(.N_ENTRIES(`WO_WR_ENTRIES)) wr_filt_if ();
    tag_heap_if    #(.N_ENTRIES(`WO_RD_ENTRIES)) rd_heap_if ();
    tag_heap_if    #(.N_ENTRIES(`WO_WR_ENTRIES)) wr_heap_if ();

    order_ctrl ctrl (
        .clk, .resetb,
        .req_valid, .req_ready, .req_is_write, .req_check_order,
        .req_addr, .req_data, .req_tag,
        .mem_almfull, .mem_req_valid, .mem_req_is_write,
        .mem_req_addr, .mem_req_data, .mem_req_idx,
        .mem_rsp_valid, .mem_rsp_is_write, .mem_rsp_idx,
        .rsp_valid, .rsp_is_write, .rsp_tag,
        .rd_filt(rd_filt_if.ctrl),
        .wr_filt(wr_filt_if.ctrl),
        .rd_heap(rd_heap_if.ctrl),
        .wr_heap(wr_heap_if.ctrl)
    );

    busy_filter #(.N_ENTRIES(`WO_RD_ENTRIES)) rd_filter (.clk, .resetb, .f(rd_filt_if.filter));
    busy_filter #(.N_ENTRIES(`WO_WR_ENTRIES)) wr_filter (.clk, .resetb, .f(wr_filt_if.filter));

    tag_heap #(.N_ENTRIES(`WO_RD_ENTRIES)) rd_heap (.clk, .resetb, .h(rd_heap_if.heap));
    tag_heap #(.N_ENTRIES(`WO_WR_ENTRIES)) wr_heap (.clk, .resetb, .h(wr_heap_if.heap));

endmodule

`default_nettype wire
